/* source/csr_pkg.sv */
package csr_pkg;

    localparam int XLEN      = 64;
    localparam int CSR_IDX_W = 12;

    // machine csr addresses
    localparam logic [CSR_IDX_W-1:0] CSR_MSTATUS   = 12'h300;
    localparam logic [CSR_IDX_W-1:0] CSR_MISA      = 12'h301;
    localparam logic [CSR_IDX_W-1:0] CSR_MIE       = 12'h304;
    localparam logic [CSR_IDX_W-1:0] CSR_MTVEC     = 12'h305;
    localparam logic [CSR_IDX_W-1:0] CSR_MSCRATCH  = 12'h340;
    localparam logic [CSR_IDX_W-1:0] CSR_MEPC      = 12'h341;
    localparam logic [CSR_IDX_W-1:0] CSR_MCAUSE    = 12'h342;
    localparam logic [CSR_IDX_W-1:0] CSR_MIP       = 12'h344;
    localparam logic [CSR_IDX_W-1:0] CSR_MCYCLE    = 12'hB00;
    localparam logic [CSR_IDX_W-1:0] CSR_MINSTRET  = 12'hB02;
    localparam logic [CSR_IDX_W-1:0] CSR_MVENDORID = 12'hF11;
    localparam logic [CSR_IDX_W-1:0] CSR_MARCHID   = 12'hF12;
    localparam logic [CSR_IDX_W-1:0] CSR_MIMPID    = 12'hF13;
    localparam logic [CSR_IDX_W-1:0] CSR_MHARTID   = 12'hF14;

    typedef enum logic [1:0] {
        CSR_NONE = 2'b00,
        CSR_RW   = 2'b01,
        CSR_RS   = 2'b10,
        CSR_RC   = 2'b11
    } csr_op_e;

    // mstatus fields, two-bit fields given by their low bit
    localparam int MSTATUS_MIE  = 3;
    localparam int MSTATUS_MPIE = 7;
    localparam int MSTATUS_MPP  = 11;
    localparam int MSTATUS_FS   = 13;
    localparam int MSTATUS_XS   = 15;

    // machine timer bit in mie and mip
    localparam int MIX_MTI = 7;

    localparam logic [XLEN-1:0] CAUSE_ECALL  = XLEN'(11);
    localparam logic [XLEN-1:0] CAUSE_BREAK  = XLEN'(3);
    localparam logic [XLEN-1:0] CAUSE_MTIMER = (XLEN'(1) << (XLEN - 1)) | XLEN'(7);

    // rv64 with the I extension
    localparam logic [XLEN-1:0] MISA_VALUE      = 64'h8000_0000_0000_0100;
    localparam logic [XLEN-1:0] MVENDORID_VALUE = '0;
    localparam logic [XLEN-1:0] MARCHID_VALUE   = XLEN'(1);
    localparam logic [XLEN-1:0] MIMPID_VALUE    = XLEN'(1);
    localparam logic [XLEN-1:0] MHARTID_VALUE   = '0;

endpackage

/* source/csr_req_if.sv */
`timescale 1ns/1ns

interface csr_req_if import csr_pkg::*; ();

    logic                 valid;
    logic                 intp_en;
    logic [CSR_IDX_W-1:0] csr_idx;
    csr_op_e              op;
    logic                 use_imm;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      pc;
    logic                 trap;
    logic                 mret;
    logic                 ecall;
    logic                 ebreak;

    // memory stage side
    modport stage (
        output valid, intp_en, csr_idx, op, use_imm, rs1_data, imm,
        output pc, trap, mret, ecall, ebreak
    );

    // csr block side
    modport csr (
        input valid, intp_en, csr_idx, op, use_imm, rs1_data, imm,
        input pc, trap, mret, ecall, ebreak
    );

endinterface

/* source/clint_timer.sv */
`timescale 1ns/1ns

module clint_timer import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    input  logic            we_i,
    input  logic            sel_cmp_i,
    input  logic [XLEN-1:0] wdata_i,
    output logic [XLEN-1:0] rdata_o,
    output logic            mtip_o,
    output logic            update_o
);

    logic [XLEN-1:0] mtime_r;
    logic [XLEN-1:0] mtimecmp_r;
    logic            update_r;
    logic            mtime_we;
    logic            mtimecmp_we;

    assign mtime_we    = we_i & ~sel_cmp_i;
    assign mtimecmp_we = we_i & sel_cmp_i;

    // free running, loaded on a write
    always_ff @(posedge clk) begin
        if (rst) begin
            mtime_r <= '0;
        end else if (mtime_we) begin
            mtime_r <= wdata_i;
        end else begin
            mtime_r <= mtime_r + XLEN'(1);
        end
    end

    // all ones so nothing is pending out of reset
    always_ff @(posedge clk) begin
        if (rst) begin
            mtimecmp_r <= '1;
        end else if (mtimecmp_we) begin
            mtimecmp_r <= wdata_i;
        end
    end

    // one cycle after a compare write
    always_ff @(posedge clk) begin
        if (rst) begin
            update_r <= 1'b0;
        end else begin
            update_r <= mtimecmp_we;
        end
    end

    assign rdata_o  = sel_cmp_i ? mtimecmp_r : mtime_r;
    assign mtip_o   = (mtime_r >= mtimecmp_r);
    assign update_o = update_r;

endmodule

/* source/mem_csr.sv */
`timescale 1ns/1ns

module mem_csr import csr_pkg::*; (
    input  logic            clk,
    input  logic            rst,
    csr_req_if.csr          req,
    input  logic            mtip_i,
    input  logic            update_i,
    output logic            csr_trap_o,
    output logic [XLEN-1:0] csr_nxt_pc_o,
    output logic [XLEN-1:0] csr_read_o
);

    // register selects
    logic sel_mstatus;
    logic sel_mie;
    logic sel_mtvec;
    logic sel_mscratch;
    logic sel_mepc;
    logic sel_mcause;
    logic sel_mip;
    logic sel_mcycle;
    logic sel_minstret;

    logic            inst_en;
    logic            wr_en;
    logic            trap_nmret;
    logic            trap_en;
    logic            ret_en;
    logic            sd_nxt;
    logic [XLEN-1:0] operand;
    logic [XLEN-1:0] csr_old;
    logic [XLEN-1:0] csr_nxt;
    logic [XLEN-1:0] mie_val;
    logic [XLEN-1:0] mip_val;

    logic [XLEN-1:0] mstatus_r;
    logic [XLEN-1:0] mtvec_r;
    logic [XLEN-1:0] mepc_r;
    logic [XLEN-1:0] mcause_r;
    logic [XLEN-1:0] mscratch_r;
    logic [XLEN-1:0] mcycle_r;
    logic [XLEN-1:0] minstret_r;
    logic            mie_mtie_r;
    logic            mip_mtip_r;

    assign sel_mstatus  = (req.csr_idx == CSR_MSTATUS);
    assign sel_mie      = (req.csr_idx == CSR_MIE);
    assign sel_mtvec    = (req.csr_idx == CSR_MTVEC);
    assign sel_mscratch = (req.csr_idx == CSR_MSCRATCH);
    assign sel_mepc     = (req.csr_idx == CSR_MEPC);
    assign sel_mcause   = (req.csr_idx == CSR_MCAUSE);
    assign sel_mip      = (req.csr_idx == CSR_MIP);
    assign sel_mcycle   = (req.csr_idx == CSR_MCYCLE);
    assign sel_minstret = (req.csr_idx == CSR_MINSTRET);

    // an interrupt slot never retires or writes
    assign inst_en    = req.valid & ~req.intp_en;
    assign wr_en      = inst_en & (req.op != CSR_NONE);
    assign trap_nmret = (req.trap & ~req.mret) | req.intp_en;
    assign trap_en    = req.valid & trap_nmret;
    assign ret_en     = req.valid & req.mret;

    assign operand = req.use_imm ? req.imm : req.rs1_data;
    assign mie_val = XLEN'(mie_mtie_r) << MIX_MTI;
    assign mip_val = XLEN'(mip_mtip_r) << MIX_MTI;

    always_comb begin
        case (req.csr_idx)
            CSR_MSTATUS:   csr_old = mstatus_r;
            CSR_MISA:      csr_old = MISA_VALUE;
            CSR_MIE:       csr_old = mie_val;
            CSR_MTVEC:     csr_old = mtvec_r;
            CSR_MSCRATCH:  csr_old = mscratch_r;
            CSR_MEPC:      csr_old = mepc_r;
            CSR_MCAUSE:    csr_old = mcause_r;
            CSR_MIP:       csr_old = mip_val;
            CSR_MCYCLE:    csr_old = mcycle_r;
            CSR_MINSTRET:  csr_old = minstret_r;
            CSR_MVENDORID: csr_old = MVENDORID_VALUE;
            CSR_MARCHID:   csr_old = MARCHID_VALUE;
            CSR_MIMPID:    csr_old = MIMPID_VALUE;
            CSR_MHARTID:   csr_old = MHARTID_VALUE;
            default:       csr_old = '0;
        endcase
    end

    always_comb begin
        case (req.op)
            CSR_RW:  csr_nxt = operand;
            CSR_RS:  csr_nxt = csr_old | operand;
            CSR_RC:  csr_nxt = csr_old & ~operand;
            default: csr_nxt = csr_old;
        endcase
    end

    // sd summarizes dirty fs or xs
    assign sd_nxt = (csr_nxt[MSTATUS_FS+:2] == 2'b11) | (csr_nxt[MSTATUS_XS+:2] == 2'b11);

    always_ff @(posedge clk) begin
        if (rst) begin
            mstatus_r <= '0;
        end else if (wr_en && sel_mstatus) begin
            mstatus_r <= {sd_nxt, csr_nxt[XLEN-2:0]};
        end else if (trap_en) begin
            mstatus_r[MSTATUS_MPP+:2] <= 2'b11;
            mstatus_r[MSTATUS_MPIE]   <= mstatus_r[MSTATUS_MIE];
            mstatus_r[MSTATUS_MIE]    <= 1'b0;
        end else if (ret_en) begin
            mstatus_r[MSTATUS_MPP+:2] <= 2'b00;
            mstatus_r[MSTATUS_MPIE]   <= 1'b1;
            mstatus_r[MSTATUS_MIE]    <= mstatus_r[MSTATUS_MPIE];
        end
    end

    // direct mode only
    always_ff @(posedge clk) begin
        if (rst) begin
            mtvec_r <= '0;
        end else if (wr_en && sel_mtvec) begin
            mtvec_r <= {csr_nxt[XLEN-1:2], 2'b00};
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mepc_r <= '0;
        end else if (wr_en && sel_mepc) begin
            mepc_r <= csr_nxt;
        end else if (trap_en) begin
            mepc_r <= req.pc;
        end
    end

    // anything trapping that is not ecall or ebreak is the timer
    always_ff @(posedge clk) begin
        if (rst) begin
            mcause_r <= '0;
        end else if (wr_en && sel_mcause) begin
            mcause_r <= csr_nxt;
        end else if (inst_en && req.ecall) begin
            mcause_r <= CAUSE_ECALL;
        end else if (inst_en && req.ebreak) begin
            mcause_r <= CAUSE_BREAK;
        end else if (trap_en) begin
            mcause_r <= CAUSE_MTIMER;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mscratch_r <= '0;
        end else if (wr_en && sel_mscratch) begin
            mscratch_r <= csr_nxt;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mie_mtie_r <= 1'b0;
        end else if (wr_en && sel_mie) begin
            mie_mtie_r <= csr_nxt[MIX_MTI];
        end
    end

    // follows the timer level, refreshed on a compare update
    always_ff @(posedge clk) begin
        if (rst) begin
            mip_mtip_r <= 1'b0;
        end else if (wr_en && sel_mip) begin
            mip_mtip_r <= csr_nxt[MIX_MTI];
        end else if (mtip_i || update_i) begin
            mip_mtip_r <= mtip_i;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            mcycle_r <= '0;
        end else if (wr_en && sel_mcycle) begin
            mcycle_r <= csr_nxt;
        end else begin
            mcycle_r <= mcycle_r + XLEN'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            minstret_r <= '0;
        end else if (wr_en && sel_minstret) begin
            minstret_r <= csr_nxt;
        end else if (inst_en) begin
            minstret_r <= minstret_r + XLEN'(1);
        end
    end

    assign csr_trap_o   = mstatus_r[MSTATUS_MIE] & mie_mtie_r & mip_mtip_r;
    assign csr_nxt_pc_o = trap_nmret ? mtvec_r : mepc_r;
    assign csr_read_o   = csr_old;

endmodule

/* source/csr_subsys.sv */
`timescale 1ns/1ns

module csr_subsys import csr_pkg::*; (
    input  logic                 clk,
    input  logic                 rst,

    // memory stage request
    input  logic                 inst_valid_i,
    input  logic                 intp_en_i,
    input  logic [CSR_IDX_W-1:0] csr_idx_i,
    input  csr_op_e              csr_op_i,
    input  logic                 csr_use_imm_i,
    input  logic [XLEN-1:0]      rs1_data_i,
    input  logic [XLEN-1:0]      imm_i,
    input  logic [XLEN-1:0]      inst_addr_i,
    input  logic                 inst_trap_i,
    input  logic                 inst_mret_i,
    input  logic                 inst_ecall_i,
    input  logic                 inst_ebreak_i,

    // timer access
    input  logic                 timer_we_i,
    input  logic                 timer_sel_cmp_i,
    input  logic [XLEN-1:0]      timer_wdata_i,
    output logic [XLEN-1:0]      timer_rdata_o,

    output logic                 csr_trap_o,
    output logic [XLEN-1:0]      csr_nxt_pc_o,
    output logic [XLEN-1:0]      csr_read_o
);

    logic timer_mtip;
    logic timer_update;

    csr_req_if req ();

    assign req.valid    = inst_valid_i;
    assign req.intp_en  = intp_en_i;
    assign req.csr_idx  = csr_idx_i;
    assign req.op       = csr_op_i;
    assign req.use_imm  = csr_use_imm_i;
    assign req.rs1_data = rs1_data_i;
    assign req.imm      = imm_i;
    assign req.pc       = inst_addr_i;
    assign req.trap     = inst_trap_i;
    assign req.mret     = inst_mret_i;
    assign req.ecall    = inst_ecall_i;
    assign req.ebreak   = inst_ebreak_i;

    clint_timer u_timer (
        .clk       (clk),
        .rst       (rst),
        .we_i      (timer_we_i),
        .sel_cmp_i (timer_sel_cmp_i),
        .wdata_i   (timer_wdata_i),
        .rdata_o   (timer_rdata_o),
        .mtip_o    (timer_mtip),
        .update_o  (timer_update)
    );

    mem_csr u_mem_csr (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .mtip_i       (timer_mtip),
        .update_i     (timer_update),
        .csr_trap_o   (csr_trap_o),
        .csr_nxt_pc_o (csr_nxt_pc_o),
        .csr_read_o   (csr_read_o)
    );

endmodule

/* tb/csr_subsys_tb.sv */
`timescale 1ns/1ns

module csr_subsys_tb import csr_pkg::*; ();

    typedef struct {
        int                   tst;
        logic                 valid;
        logic                 intp;
        logic [CSR_IDX_W-1:0] idx;
        csr_op_e              op;
        logic                 use_imm;
        logic [XLEN-1:0]      rs1;
        logic [XLEN-1:0]      imm;
        logic [XLEN-1:0]      pc;
        logic                 trap;
        logic                 mret;
        logic                 ecall;
        logic                 ebreak;
        logic                 tmr_we;
        logic                 tmr_sel;
        logic [XLEN-1:0]      tmr_data;
        logic                 chk;
    } step_t;

    logic                 clk;
    logic                 rst;
    logic                 inst_valid;
    logic                 intp_en;
    logic [CSR_IDX_W-1:0] csr_idx;
    csr_op_e              csr_op;
    logic                 csr_use_imm;
    logic [XLEN-1:0]      rs1_data;
    logic [XLEN-1:0]      imm;
    logic [XLEN-1:0]      inst_addr;
    logic                 inst_trap;
    logic                 inst_mret;
    logic                 inst_ecall;
    logic                 inst_ebreak;
    logic                 timer_we;
    logic                 timer_sel_cmp;
    logic [XLEN-1:0]      timer_wdata;
    logic [XLEN-1:0]      timer_rdata;
    logic                 csr_trap;
    logic [XLEN-1:0]      csr_nxt_pc;
    logic [XLEN-1:0]      csr_read;

    // reference model state
    logic [XLEN-1:0] m_status;
    logic [XLEN-1:0] m_tvec;
    logic [XLEN-1:0] m_epc;
    logic [XLEN-1:0] m_cause;
    logic [XLEN-1:0] m_scratch;
    logic            m_tie;
    logic            m_tip;

    logic [XLEN-1:0] last_read;
    logic [XLEN-1:0] last_timer;
    logic            last_trap;
    logic [XLEN-1:0] cyc = '0;
    step_t           tbl[$];
    int              err_cnt = 0;
    int              chk_cnt = 0;
    int              test_cnt = 0;
    int              test_fail = 0;
    int              test_err0 = 0;
    string           cur_name;

    csr_subsys UUT (
        .clk(clk), .rst(rst), .inst_valid_i(inst_valid), .intp_en_i(intp_en),
        .csr_idx_i(csr_idx), .csr_op_i(csr_op), .csr_use_imm_i(csr_use_imm),
        .rs1_data_i(rs1_data), .imm_i(imm), .inst_addr_i(inst_addr),
        .inst_trap_i(inst_trap), .inst_mret_i(inst_mret), .inst_ecall_i(inst_ecall),
        .inst_ebreak_i(inst_ebreak), .timer_we_i(timer_we), .timer_sel_cmp_i(timer_sel_cmp),
        .timer_wdata_i(timer_wdata), .timer_rdata_o(timer_rdata), .csr_trap_o(csr_trap),
        .csr_nxt_pc_o(csr_nxt_pc), .csr_read_o(csr_read)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cyc <= cyc + 64'd1;

    task automatic check_data(input string what, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_pc(input string what, input logic [XLEN-1:0] got,
                            input logic [XLEN-1:0] exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: next pc %s is %h, expected %h", $time, what, got, exp);
        end
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("CHECK FAILED at %0t ns: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    function automatic logic [XLEN-1:0] model_read(input logic [CSR_IDX_W-1:0] idx);
        case (idx)
            CSR_MSTATUS:   return m_status;
            CSR_MISA:      return MISA_VALUE;
            CSR_MIE:       return {56'd0, m_tie, 7'd0};
            CSR_MTVEC:     return m_tvec;
            CSR_MSCRATCH:  return m_scratch;
            CSR_MEPC:      return m_epc;
            CSR_MCAUSE:    return m_cause;
            CSR_MIP:       return {56'd0, m_tip, 7'd0};
            CSR_MVENDORID: return MVENDORID_VALUE;
            CSR_MARCHID:   return MARCHID_VALUE;
            CSR_MIMPID:    return MIMPID_VALUE;
            CSR_MHARTID:   return MHARTID_VALUE;
            default:       return '0;
        endcase
    endfunction

    task automatic model_update(input step_t s);
        logic [XLEN-1:0] old;
        logic [XLEN-1:0] opnd;
        logic [XLEN-1:0] nxt;
        logic [XLEN-1:0] st;
        logic            inst;
        logic            wr;
        logic            trp;
        old  = model_read(s.idx);
        opnd = s.use_imm ? s.imm : s.rs1;
        case (s.op)
            CSR_RW:  nxt = opnd;
            CSR_RS:  nxt = old | opnd;
            CSR_RC:  nxt = old & ~opnd;
            default: nxt = old;
        endcase
        inst = s.valid & ~s.intp;
        wr   = inst & (s.op != CSR_NONE);
        trp  = s.valid & ((s.trap & ~s.mret) | s.intp);
        st   = m_status;
        if (wr && s.idx == CSR_MSTATUS) begin
            st = {(nxt[14:13] == 2'b11) | (nxt[16:15] == 2'b11), nxt[62:0]};
        end else if (trp) begin
            st[12:11] = 2'b11;
            st[7]     = m_status[3];
            st[3]     = 1'b0;
        end else if (s.valid && s.mret) begin
            st[12:11] = 2'b00;
            st[7]     = 1'b1;
            st[3]     = m_status[7];
        end
        m_status = st;
        if (wr && s.idx == CSR_MTVEC) m_tvec = nxt & ~64'd3;
        if (wr && s.idx == CSR_MSCRATCH) m_scratch = nxt;
        if (wr && s.idx == CSR_MIE) m_tie = nxt[7];
        if (wr && s.idx == CSR_MEPC) m_epc = nxt;
        else if (trp) m_epc = s.pc;
        if (wr && s.idx == CSR_MCAUSE) m_cause = nxt;
        else if (inst && s.ecall) m_cause = 64'd11;
        else if (inst && s.ebreak) m_cause = 64'd3;
        else if (trp) m_cause = 64'h8000_0000_0000_0007;
    endtask

    // every DUT input except clock and reset
    task automatic drive_inputs(input step_t s);
        inst_valid    = s.valid;
        intp_en       = s.intp;
        csr_idx       = s.idx;
        csr_op        = s.op;
        csr_use_imm   = s.use_imm;
        rs1_data      = s.rs1;
        imm           = s.imm;
        inst_addr     = s.pc;
        inst_trap     = s.trap;
        inst_mret     = s.mret;
        inst_ecall    = s.ecall;
        inst_ebreak   = s.ebreak;
        timer_we      = s.tmr_we;
        timer_sel_cmp = s.tmr_sel;
        timer_wdata   = s.tmr_data;
    endtask

    // drive on the falling edge, sample mid low phase
    task automatic run_step(input step_t s);
        logic [XLEN-1:0] exp_pc;
        @(negedge clk);
        drive_inputs(s);
        #5;
        last_read  = csr_read;
        last_timer = timer_rdata;
        last_trap  = csr_trap;
        exp_pc = ((s.trap && !s.mret) || s.intp) ? m_tvec : m_epc;
        if (s.chk) begin
            check_data($sformatf("csr %h", s.idx), csr_read, model_read(s.idx));
            check_pc($sformatf("with csr %h", s.idx), csr_nxt_pc, exp_pc);
            check_bit("trap level", csr_trap, m_status[3] & m_tie & m_tip);
        end
        model_update(s);
    endtask

    function automatic step_t mk(input int tst, input logic [CSR_IDX_W-1:0] idx,
                                 input csr_op_e op, input logic use_imm,
                                 input logic [XLEN-1:0] val);
        step_t s;
        s = '{tst, 1'b1, 1'b0, idx, op, use_imm, use_imm ? '0 : val, use_imm ? val : '0,
              '0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0, 1'b1};
        return s;
    endfunction

    task automatic start_test(input string name);
        cur_name  = name;
        test_err0 = err_cnt;
    endtask

    task automatic finish_test();
        test_cnt++;
        if (err_cnt == test_err0) begin
            $display("test %s: ok", cur_name);
        end else begin
            test_fail++;
            $display("test %s: %0d errors", cur_name, err_cnt - test_err0);
        end
    endtask

    task automatic report_timeout(input string why);
        err_cnt++;
        $display("%s", why);
    endtask

    task automatic build_table();
        logic [CSR_IDX_W-1:0] ids[5];
        step_t                s;
        ids = '{CSR_MISA, CSR_MARCHID, CSR_MIMPID, CSR_MVENDORID, CSR_MHARTID};
        tbl.push_back(mk(0, CSR_MSCRATCH, CSR_RW, 1'b0, {$urandom, $urandom}));
        tbl.push_back(mk(0, CSR_MSCRATCH, CSR_RS, 1'b1, {$urandom, $urandom}));
        tbl.push_back(mk(0, CSR_MSCRATCH, CSR_RC, 1'b0, {$urandom, $urandom}));
        tbl.push_back(mk(0, CSR_MSCRATCH, CSR_NONE, 1'b0, '0));
        // low two bits set in the written value
        tbl.push_back(mk(0, CSR_MTVEC, CSR_RW, 1'b0, {$urandom, $urandom} | 64'h3));
        tbl.push_back(mk(0, CSR_MTVEC, CSR_NONE, 1'b0, '0));
        tbl.push_back(mk(0, CSR_MIE, CSR_RW, 1'b0, '1));
        tbl.push_back(mk(0, CSR_MIE, CSR_NONE, 1'b0, '0));
        foreach (ids[i]) begin
            tbl.push_back(mk(1, ids[i], CSR_RW, 1'b0, {$urandom, $urandom}));
            tbl.push_back(mk(1, ids[i], CSR_NONE, 1'b0, '0));
        end
        tbl.push_back(mk(2, CSR_MSTATUS, CSR_RS, 1'b1, 64'h8));
        s = mk(2, CSR_MSCRATCH, CSR_NONE, 1'b0, '0);
        s.trap  = 1'b1;
        s.ecall = 1'b1;
        s.pc    = {$urandom, $urandom};
        tbl.push_back(s);
        tbl.push_back(mk(2, CSR_MEPC, CSR_NONE, 1'b0, '0));
        tbl.push_back(mk(2, CSR_MCAUSE, CSR_NONE, 1'b0, '0));
        tbl.push_back(mk(2, CSR_MSTATUS, CSR_NONE, 1'b0, '0));
        s.ecall  = 1'b0;
        s.ebreak = 1'b1;
        s.pc     = {$urandom, $urandom};
        tbl.push_back(s);
        tbl.push_back(mk(2, CSR_MCAUSE, CSR_NONE, 1'b0, '0));
        // mie set, mpie clear and mpp at 3 ahead of the return
        tbl.push_back(mk(3, CSR_MSTATUS, CSR_RW, 1'b0, 64'h1808));
        s = mk(3, CSR_MEPC, CSR_NONE, 1'b0, '0);
        s.mret = 1'b1;
        tbl.push_back(s);
        tbl.push_back(mk(3, CSR_MSTATUS, CSR_NONE, 1'b0, '0));
    endtask

    initial begin
        string           names[4];
        step_t           s;
        logic [XLEN-1:0] a;
        logic [XLEN-1:0] n1;
        int              n;
        names = '{"csr read-modify-write", "identification registers", "ecall and ebreak",
                  "mret"};
        void'($urandom(32'h1d4db7bf));
        s = mk(0, '0, CSR_NONE, 1'b0, '0);
        s.valid = 1'b0;
        {m_status, m_tvec, m_epc, m_cause, m_scratch, m_tie, m_tip} = '0;
        rst = 1'b1;
        drive_inputs(s);
        repeat (2) @(negedge clk);
        rst = 1'b0;
        build_table();
        for (int i = 0; i < tbl.size(); i++) begin
            if (i == 0 || tbl[i].tst != tbl[i-1].tst) start_test(names[tbl[i].tst]);
            run_step(tbl[i]);
            if (i == tbl.size() - 1 || tbl[i+1].tst != tbl[i].tst) finish_test();
        end

        start_test("timer interrupt");
        run_step(mk(4, CSR_MSTATUS, CSR_RS, 1'b1, 64'h8));
        s = mk(4, CSR_MSTATUS, CSR_NONE, 1'b0, '0);
        s.valid  = 1'b0;
        s.tmr_we = 1'b1;
        run_step(s);
        s.tmr_sel  = 1'b1;
        s.tmr_data = 64'd20;
        run_step(s);
        s.tmr_we = 1'b0;
        run_step(s);
        check_data("mtimecmp", last_timer, 64'd20);
        s.chk = 1'b0;
        n = 0;
        do begin
            run_step(s);
            n++;
        end while (!last_trap && n < 100);
        if (!last_trap) report_timeout("timer interrupt did not reach the trap output in 100 cycles");
        m_tip = 1'b1;
        s = mk(4, CSR_MCAUSE, CSR_NONE, 1'b0, '0);
        s.intp = 1'b1;
        s.pc   = {$urandom, $urandom};
        run_step(s);
        run_step(mk(4, CSR_MCAUSE, CSR_NONE, 1'b0, '0));
        run_step(mk(4, CSR_MEPC, CSR_NONE, 1'b0, '0));
        s = mk(4, CSR_MIP, CSR_NONE, 1'b0, '0);
        s.valid    = 1'b0;
        s.tmr_we   = 1'b1;
        s.tmr_sel  = 1'b1;
        s.tmr_data = '1;
        run_step(s);
        s.tmr_we = 1'b0;
        s.chk    = 1'b0;
        n = 0;
        do begin
            run_step(s);
            n++;
        end while (last_read[7] && n < 20);
        if (last_read[7]) report_timeout("mip timer bit stayed set after the compare was moved");
        m_tip = 1'b0;
        s.chk = 1'b1;
        run_step(s);
        finish_test();

        start_test("counters");
        s = mk(5, CSR_MINSTRET, CSR_NONE, 1'b0, '0);
        s.valid = 1'b0;
        s.chk   = 1'b0;
        run_step(s);
        a = last_read;
        s.valid = 1'b1;
        repeat (5) run_step(s);
        // interrupt slot does not retire
        s.intp = 1'b1;
        run_step(s);
        s.intp  = 1'b0;
        s.valid = 1'b0;
        run_step(s);
        check_data("minstret delta", last_read - a, 64'd5);
        s.idx = CSR_MCYCLE;
        run_step(s);
        a  = last_read;
        n1 = cyc;
        repeat (7) run_step(s);
        check_data("mcycle delta", last_read - a, cyc - n1);
        finish_test();

        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 test_cnt, test_fail, chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

/* csr_subsys.f */
source/csr_pkg.sv
source/csr_req_if.sv
source/clint_timer.sv
source/mem_csr.sv
source/csr_subsys.sv
tb/csr_subsys_tb.sv

/* Makefile */
BIN = obj_dir/Vcsr_subsys_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing -sv -f csr_subsys.f --top-module csr_subsys_tb -Mdir obj_dir

run: compile
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "All checks passed"

clean:
	rm -rf obj_dir
